/* src/padframe_macros.svh */
// Pad count, mode-word layout and synchronizer depth, included by the package and RTL files
`ifndef PADFRAME_MACROS_SVH
`define PADFRAME_MACROS_SVH

`define PAD_COUNT       8	// Digital user pads in this slice
`define PAD_IDX_W       3	// Pad index width
`define CFG_W           5	// Mode word width

// Mode word layout
`define CFG_OEB_BIT     0	// Output enable, active low
`define CFG_INP_DIS_BIT 1	// Input disable
`define CFG_DM_LSB      2	// Drive mode lsb
`define DM_W            3	// Drive mode width

// Output off, input on, drive mode 1 (floating input)
`define CFG_RESET_WORD  5'b001_01

`define SYNC_STAGES     2	// Pad input synchronizer depth

`endif

/* src/padframe_pkg.sv */
// Shared types for the user padframe slice, imported by every RTL file
`include "padframe_macros.svh"

package padframe_pkg;

	// Pad select on the config port
	typedef logic [`PAD_IDX_W-1:0] pad_idx_t;

	// One pad mode word {dm, inp_dis, oeb}
	typedef logic [`CFG_W-1:0] pad_cfg_t;

	// Drive mode field
	// 0 analog, 1 float in, 2 pull-down, 3 pull-up, 4..7 drive
	typedef logic [`DM_W-1:0] dm_t;

	typedef logic [`PAD_COUNT-1:0] pad_vec_t;	// One bit per pad

	// Config receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE    = 2'd0,	// Waiting for cfg_req
		RX_ACCESS  = 2'd1,	// One-cycle strobe to the bank
		RX_ACK     = 2'd2,	// Ack high, waiting for req to drop
		RX_RELEASE = 2'd3	// Req seen low, ack drops next edge
	} rx_state_t;

endpackage

/* src/cfg_bus_if.sv */
// Internal config access bus between the handshake receiver and the mode register bank
interface cfg_bus_if import padframe_pkg::*; ();

	logic     acc_valid;	// Single-cycle access strobe
	logic     acc_we;	// Write qualifier, only with acc_valid
	pad_idx_t acc_addr;	// Pad select
	pad_cfg_t acc_wdata;	// New mode word
	pad_cfg_t acc_rdata;	// Read word, cycle after the strobe

	// Handshake side issues accesses
	modport receiver (
		output acc_valid,
		output acc_we,
		output acc_addr,
		output acc_wdata,
		input  acc_rdata
	);

	// Register side answers them
	modport bank (
		input  acc_valid,
		input  acc_we,
		input  acc_addr,
		input  acc_wdata,
		output acc_rdata
	);

endinterface

/* src/cfg_receiver.sv */
// Four-phase req/ack slave for the management config port, one bank access per request
`include "padframe_macros.svh"

module cfg_receiver import padframe_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      cfg_req,
	input  logic      cfg_we,
	input  pad_idx_t  cfg_addr,
	input  pad_cfg_t  cfg_wdata,
	output logic      cfg_ack,
	output pad_cfg_t  cfg_rdata,
	cfg_bus_if.receiver acc
);

	rx_state_t state;
	rx_state_t state_nxt;
	logic      we_q;	// Request fields, latched at req
	pad_idx_t  addr_q;
	pad_cfg_t  wdata_q;

	always_comb begin
		state_nxt = state;
		case (state)
			RX_IDLE: begin
				if (cfg_req) begin
					state_nxt = RX_ACCESS;
				end
			end
			RX_ACCESS: state_nxt = RX_ACK;	// Strobe lasts one cycle
			RX_ACK: begin
				if (!cfg_req) begin	// Master saw ack
					state_nxt = RX_RELEASE;
				end
			end
			default: state_nxt = RX_IDLE;	// RX_RELEASE
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RX_IDLE;
			cfg_ack <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == RX_ACCESS) begin
				cfg_ack <= 1'b1;	// Bank read word lands on this edge too
			end else if (state == RX_RELEASE) begin
				cfg_ack <= 1'b0;	// One cycle after req seen low
			end
		end
	end

	// Master holds the fields until ack, grab them once
	always_ff @(posedge clock) begin
		if (state == RX_IDLE && cfg_req) begin
			we_q    <= cfg_we;
			addr_q  <= cfg_addr;
			wdata_q <= cfg_wdata;
		end
	end

	assign acc.acc_valid = (state == RX_ACCESS);
	assign acc.acc_we    = (state == RX_ACCESS) && we_q;	// Never outside the strobe
	assign acc.acc_addr  = addr_q;
	assign acc.acc_wdata = wdata_q;

	// Bank read register only moves on a read strobe, so it is steady for the whole ack phase
	assign cfg_rdata = acc.acc_rdata;

	a_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(cfg_ack) |-> cfg_req);
	// New request only once the previous ack has dropped
	a_req_after_ack_low: assert property (@(posedge clock) disable iff (reset)
		$rose(cfg_req) |-> !cfg_ack);

endmodule

/* src/pad_cfg_bank.sv */
// Per-pad mode word registers, written and read over the config bus, fed flat to the pad ring
`include "padframe_macros.svh"

module pad_cfg_bank import padframe_pkg::*; (
	input  logic clock,
	input  logic reset,
	cfg_bus_if.bank acc,
	output logic [`PAD_COUNT*`CFG_W-1:0] pad_cfg_flat
);

	pad_cfg_t cfg_q [`PAD_COUNT];	// Live mode words
	pad_cfg_t rdata_q;	// Readback holding register

	// Mode words, reset to a safe input-only state
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `PAD_COUNT; i++) begin
				cfg_q[i] <= `CFG_RESET_WORD;
			end
		end else if (acc.acc_valid && acc.acc_we) begin
			cfg_q[acc.acc_addr] <= acc.acc_wdata;	// Visible on pins next cycle
		end
	end

	// Read word appears the cycle after the strobe
	always_ff @(posedge clock) begin
		if (acc.acc_valid && !acc.acc_we) begin
			rdata_q <= cfg_q[acc.acc_addr];
		end
	end

	assign acc.acc_rdata = rdata_q;	// Held until the next read

	// Flatten for the pad ring, pad 0 in the low bits
	always_comb begin
		for (int i = 0; i < `PAD_COUNT; i++) begin
			pad_cfg_flat[i*`CFG_W +: `CFG_W] = cfg_q[i];
		end
	end

	// Write qualifier comes only with the receiver strobe
	a_we_in_strobe: assert property (@(posedge clock) disable iff (reset)
		acc.acc_we |-> acc.acc_valid);

endmodule

/* src/pad_ring.sv */
// Applies mode words and power-on gating to the user pad pins and syncs pad inputs to the core
`include "padframe_macros.svh"

module pad_ring import padframe_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     porb_h,	// Power good, low gates every pad
	input  logic [`PAD_COUNT*`CFG_W-1:0] pad_cfg_flat,
	input  pad_vec_t io_out,	// Core output data
	input  pad_vec_t pad_in,	// Raw pin level, async to clock
	output pad_vec_t pad_oe,
	output pad_vec_t pad_out,
	output pad_vec_t pad_pu,
	output pad_vec_t pad_pd,
	output pad_vec_t io_in
);

	pad_vec_t oeb;
	pad_vec_t inp_dis;
	dm_t      dm [`PAD_COUNT];
	pad_vec_t sync_q [`SYNC_STAGES];	// Stage 0 faces the pin

	// Split the flat mode words into fields
	always_comb begin
		for (int i = 0; i < `PAD_COUNT; i++) begin
			oeb[i]     = pad_cfg_flat[i*`CFG_W + `CFG_OEB_BIT];
			inp_dis[i] = pad_cfg_flat[i*`CFG_W + `CFG_INP_DIS_BIT];
			dm[i]      = pad_cfg_flat[i*`CFG_W + `CFG_DM_LSB +: `DM_W];
		end
	end

	// Pin controls, all forced off without porb_h
	always_comb begin
		for (int i = 0; i < `PAD_COUNT; i++) begin
			// Modes 4..7 have the dm msb set
			pad_oe[i] = porb_h && !oeb[i] && dm[i][`DM_W-1];
			pad_out[i] = porb_h && io_out[i];
			pad_pu[i]  = porb_h && (dm[i] == dm_t'(3));	// Input with pull-up
			pad_pd[i]  = porb_h && (dm[i] == dm_t'(2));	// Input with pull-down
		end
	end

	// Input synchronizer
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < `SYNC_STAGES; s++) begin
				sync_q[s] <= '0;
			end
		end else begin
			sync_q[0] <= pad_in;
			for (int s = 1; s < `SYNC_STAGES; s++) begin
				sync_q[s] <= sync_q[s-1];
			end
		end
	end

	// Core input, blanked for disabled inputs and analog mode
	always_comb begin
		for (int i = 0; i < `PAD_COUNT; i++) begin
			io_in[i] = porb_h && !inp_dis[i] && (dm[i] != '0)
				&& sync_q[`SYNC_STAGES-1][i];
		end
	end

	// Driver and pulls never on together on one pad
	a_no_drive_with_pull: assert property (@(posedge clock) disable iff (reset)
		(pad_oe & (pad_pu | pad_pd)) == '0);

endmodule

/* src/user_padframe.sv */
// Top of the user padframe slice, config port plus digital pad pins as plain ports
`include "padframe_macros.svh"

module user_padframe import padframe_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     porb_h,	// Power-on good from the 3.3V domain

	// Management config port, four-phase
	input  logic     cfg_req,
	input  logic     cfg_we,
	input  pad_idx_t cfg_addr,
	input  pad_cfg_t cfg_wdata,
	output logic     cfg_ack,
	output pad_cfg_t cfg_rdata,

	// Core side of the user pads
	input  pad_vec_t io_out,
	output pad_vec_t io_in,

	// Pin side, split instead of inout
	input  pad_vec_t pad_in,
	output pad_vec_t pad_oe,
	output pad_vec_t pad_out,
	output pad_vec_t pad_pu,
	output pad_vec_t pad_pd
);

	cfg_bus_if cfg_bus ();	// Receiver to bank
	logic [`PAD_COUNT*`CFG_W-1:0] pad_cfg_flat;	// All mode words

	cfg_receiver u_rx (
		.clock     (clock),
		.reset     (reset),
		.cfg_req   (cfg_req),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_ack   (cfg_ack),
		.cfg_rdata (cfg_rdata),
		.acc       (cfg_bus.receiver)
	);

	pad_cfg_bank u_bank (
		.clock        (clock),
		.reset        (reset),
		.acc          (cfg_bus.bank),
		.pad_cfg_flat (pad_cfg_flat)
	);

	pad_ring u_ring (
		.clock        (clock),
		.reset        (reset),
		.porb_h       (porb_h),
		.pad_cfg_flat (pad_cfg_flat),
		.io_out       (io_out),
		.pad_in       (pad_in),
		.pad_oe       (pad_oe),
		.pad_out      (pad_out),
		.pad_pu       (pad_pu),
		.pad_pd       (pad_pd),
		.io_in        (io_in)
	);

endmodule

/* sim/tb_user_padframe.sv */
// Testbench for the user padframe, replays the pattern file through the config port and pad pins
`include "padframe_macros.svh"

module tb_user_padframe;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES  = 10;
	localparam int CYCLES_PER_OP = 60;	// Budget per pattern line
	localparam int MAX_OPS       = 64;

	logic clock;
	logic reset;
	logic porb_h;
	logic cfg_req;
	logic cfg_we;
	logic [`PAD_IDX_W-1:0] cfg_addr;
	logic [`CFG_W-1:0] cfg_wdata;
	logic cfg_ack;
	logic [`CFG_W-1:0] cfg_rdata;
	logic [`PAD_COUNT-1:0] io_out;
	logic [`PAD_COUNT-1:0] io_in;
	logic [`PAD_COUNT-1:0] pad_in;
	logic [`PAD_COUNT-1:0] pad_oe;
	logic [`PAD_COUNT-1:0] pad_out;
	logic [`PAD_COUNT-1:0] pad_pu;
	logic [`PAD_COUNT-1:0] pad_pd;

	logic [7:0] op_kind [MAX_OPS];	// W, R or P
	logic [7:0] op_f [MAX_OPS][8];	// Fields in file order
	int n_ops;
	int error_count = 0;
	int cycle_count = 0;
	int cycle_limit = CYCLES_PER_OP * MAX_OPS + RESET_CYCLES;	// Tightened after load
	integer seed = 32'h26b7;

	user_padframe dut0 (
		.clock     (clock),
		.reset     (reset),
		.porb_h    (porb_h),
		.cfg_req   (cfg_req),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_ack   (cfg_ack),
		.cfg_rdata (cfg_rdata),
		.io_out    (io_out),
		.io_in     (io_in),
		.pad_in    (pad_in),
		.pad_oe    (pad_oe),
		.pad_out   (pad_out),
		.pad_pu    (pad_pu),
		.pad_pd    (pad_pd)
	);

	always #5 clock = ~clock;	// 10 ns period

	// Run limit
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the test did not finish within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$fatal(1, "run aborted");
		end
	end

	task automatic check_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic stop_on_bad_line(input int got, input int want);
		if (got != want) begin
			$display("Pattern line %0d has %0d fields instead of %0d", n_ops, got, want);
			$display("TB FAILED");
			$fatal(1, "unreadable pattern file");
		end
	endtask

	// Parse every operation line, skipping # comments
	task automatic load_patterns();
		int fd;
		int ch;
		int got;
		fd = $fopen("sim/padframe_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file sim/padframe_patterns.txt");
			$display("TB FAILED");
			$fatal(1, "no stimulus");
		end
		n_ops = 0;
		ch = $fgetc(fd);
		while (ch != -1 && n_ops < MAX_OPS) begin
			if (ch[7:0] == "#") begin
				while (ch != -1 && ch[7:0] != "\n") begin
					ch = $fgetc(fd);
				end
			end else if (ch[7:0] == "W" || ch[7:0] == "R") begin
				op_kind[n_ops] = ch[7:0];
				got = $fscanf(fd, "%h %h", op_f[n_ops][0], op_f[n_ops][1]);
				stop_on_bad_line(got, 2);
				n_ops++;
			end else if (ch[7:0] == "P") begin
				op_kind[n_ops] = ch[7:0];
				got = $fscanf(fd, "%h %h %h %h %h %h %h %h", op_f[n_ops][0], op_f[n_ops][1],
					op_f[n_ops][2], op_f[n_ops][3], op_f[n_ops][4], op_f[n_ops][5],
					op_f[n_ops][6], op_f[n_ops][7]);
				stop_on_bad_line(got, 8);
				n_ops++;
			end
			ch = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// One four-phase transfer, read word taken while ack is high
	task automatic cfg_access(input logic we, input logic [7:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		@(posedge clock);
		cfg_we    <= we;
		cfg_addr  <= addr[`PAD_IDX_W-1:0];
		cfg_wdata <= wdata[`CFG_W-1:0];
		cfg_req   <= 1'b1;
		@(negedge clock);
		while (!cfg_ack) @(negedge clock);
		rdata = 8'(cfg_rdata);
		@(posedge clock);
		cfg_req <= 1'b0;
		@(negedge clock);
		while (cfg_ack) @(negedge clock);	// Ack low before the next request
	endtask

	// Apply pin levels, let the synchronizer settle, then compare all pad outputs
	task automatic pin_step(input int i);
		@(posedge clock);
		porb_h <= op_f[i][0][0];
		io_out <= op_f[i][1];
		pad_in <= op_f[i][2];
		repeat (`SYNC_STAGES + 1) @(posedge clock);
		@(negedge clock);
		check_value("pad_oe", op_f[i][3], pad_oe);
		check_value("pad_out", op_f[i][4], pad_out);
		check_value("pad_pu", op_f[i][5], pad_pu);
		check_value("pad_pd", op_f[i][6], pad_pd);
		check_value("io_in", op_f[i][7], io_in);
	endtask

	initial begin
		logic [7:0] rd;
		int gap;
		clock = 1'b0;
		reset     <= 1'b1;
		porb_h    <= 1'b1;
		cfg_req   <= 1'b0;
		cfg_we    <= 1'b0;
		cfg_addr  <= '0;
		cfg_wdata <= '0;
		io_out    <= '0;
		pad_in    <= '0;
		load_patterns();
		cycle_limit = CYCLES_PER_OP * n_ops + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < n_ops; i++) begin
			case (op_kind[i])
				"W": cfg_access(1'b1, op_f[i][0], op_f[i][1], rd);
				"R": begin
					cfg_access(1'b0, op_f[i][0], 8'h00, rd);
					check_value("cfg_rdata", op_f[i][1], rd);
				end
				default: pin_step(i);
			endcase
			gap = $unsigned($random(seed)) % 4;	// Idle cycles between operations
			repeat (gap) @(posedge clock);
		end
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* user_padframe.f */
+incdir+src
src/padframe_pkg.sv
src/cfg_bus_if.sv
src/cfg_receiver.sv
src/pad_cfg_bank.sv
src/pad_ring.sv
src/user_padframe.sv
sim/tb_user_padframe.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_user_padframe
RTL_TOP   := user_padframe
FILELIST  := user_padframe.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/padframe_patterns.txt */
# W addr word | R addr expected_word | P porb_h io_out pad_in, then expected
# pad_oe pad_out pad_pu pad_pd io_in; all fields hex, word = {dm, inp_dis, oeb}
P 1 a5 3c 00 a5 00 00 3c
R 0 05
W 0 10
R 1 05
W 1 15
R 2 05
W 2 08
R 3 05
W 3 0c
R 4 05
W 4 06
R 5 05
W 5 00
R 6 05
W 6 1e
R 7 05
W 7 18
R 0 10
R 1 15
R 2 08
R 3 0c
R 4 06
R 5 00
R 6 1e
R 7 18
P 1 5a ff c1 5a 08 04 8f
P 1 a5 3c c1 a5 08 04 0c
# Power-on low blanks every pad, config port still works
P 0 ff ff 00 00 00 00 00
W 5 1d
R 5 1d
P 0 5a a5 00 00 00 00 00
P 1 00 ff c1 00 08 04 af
